/* Bender.yml */
package:
  name: glb_tile

sources:
  - design/glb_pkg.sv
  - design/glb_cfg_apb.sv
  - design/glb_load_dma.sv
  - design/glb_store_dma.sv
  - design/glb_bank_arbiter.sv
  - design/glb_bank.sv
  - design/glb_tile.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_glb_tile.sv

/* all.f */
design/glb_pkg.sv
design/glb_cfg_apb.sv
design/glb_load_dma.sv
design/glb_store_dma.sv
design/glb_bank_arbiter.sv
design/glb_bank.sv
design/glb_tile.sv
tb/tb_clk_gen.sv
tb/tb_glb_tile.sv

/* design/glb_bank.sv */
// word addressed by addr above the bank byte offset; never a read and a write together
`timescale 1ns/1ns

module glb_bank import glb_pkg::*; #(
    parameter int BANK_DEPTH = 256
) (
    input  logic      clk,
    input  bank_req_t bank_req,
    output bank_rsp_t bank_rsp
);

    localparam int IDX_W = $clog2(BANK_DEPTH);

    bank_data_t mem [BANK_DEPTH];
    logic [IDX_W-1:0] idx;

    assign idx = bank_req.addr[BANK_BYTE_OFFSET +: IDX_W];

    always_ff @(posedge clk) begin
        if (bank_req.wr_en) begin
            mem[idx] <= bank_req.wr_data;
        end
        // registered read, one cycle
        bank_rsp.rd_data_valid <= bank_req.rd_en;
        if (bank_req.rd_en) begin
            bank_rsp.rd_data <= mem[idx];
        end
    end

endmodule

/* design/glb_bank_arbiter.sv */
// store always wins; responses go to the load DMA only
`timescale 1ns/1ns

module glb_bank_arbiter import glb_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  bank_req_t store_req,
    output logic      store_gnt,
    input  bank_req_t load_req,
    output logic      load_gnt,
    output bank_req_t bank_req,
    input  bank_rsp_t bank_rsp_in,
    output bank_rsp_t load_rsp
);

    logic store_active;
    logic rd_pending;

    assign store_active = store_req.rd_en | store_req.wr_en;
    assign store_gnt = store_active;
    assign load_gnt = ~store_active;
    assign bank_req = store_active ? store_req : load_req;

    // a read issued last cycle has its data on the bank output now
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= bank_req.rd_en;
        end
    end

    assign load_rsp.rd_data_valid = rd_pending & bank_rsp_in.rd_data_valid;
    assign load_rsp.rd_data = bank_rsp_in.rd_data;

    // a stalled load read stays on the port until it wins
    a_load_req_held: assert property (@(posedge clk) disable iff (reset)
        load_req.rd_en && !load_gnt |=> load_req.rd_en && $stable(load_req.addr));

endmodule

/* design/glb_cfg_apb.sv */
// pready is tied high; offsets with nonzero low two bits or outside the map give pslverr
`timescale 1ns/1ns

module glb_cfg_apb import glb_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_addr_t              paddr,
    input  apb_data_t              pwdata,
    output apb_data_t              prdata,
    output logic                   pready,
    output logic                   pslverr,
    output dma_mode_e              load_mode,
    output dma_ld_header_t         load_header [QUEUE_DEPTH],
    input  logic [QUEUE_DEPTH-1:0] load_invalidate_pulse,
    output logic                   strm_start_pulse,
    output glb_addr_t              store_start_addr
);

    localparam int QW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic [APB_ADDR_WIDTH-5:0] row;
    logic [1:0] field;
    logic [QW-1:0] hdr_sel;
    logic hit;
    logic is_hdr;
    logic wr;
    dma_ld_header_t hdr [QUEUE_DEPTH];
    dma_ld_header_t h;

    // row 0 holds the control registers, row q+1 holds header q
    assign row = paddr[APB_ADDR_WIDTH-1:4];
    assign field = paddr[3:2];
    assign hdr_sel = QW'(row - 1'b1);
    assign h = hdr[hdr_sel];

    always_comb begin
        hit = 1'b0;
        is_hdr = 1'b0;
        prdata = '0;
        if (paddr[1:0] == 2'b00) begin
            if (row == '0) begin
                hit = (field != 2'd3);
                if (field == 2'd0) begin
                    prdata = apb_data_t'(load_mode);
                end else if (field == 2'd2) begin
                    prdata = apb_data_t'(store_start_addr);
                end
            end else if (row <= QUEUE_DEPTH) begin
                hit = 1'b1;
                is_hdr = 1'b1;
                case (field)
                    2'd0: prdata = apb_data_t'(h.start_addr);
                    2'd1: prdata = {6'b0, h.iteration.range[1], 6'b0, h.iteration.range[0]};
                    2'd2: prdata = {h.iteration.stride[1], h.iteration.stride[0]};
                    default: prdata = apb_data_t'(h.valid);
                endcase
            end
        end
    end

    assign pready = 1'b1;
    assign pslverr = psel & penable & ~hit;
    assign wr = psel & penable & pwrite & hit;
    assign load_header = hdr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_mode <= OFF;
            store_start_addr <= '0;
            strm_start_pulse <= 1'b0;
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                hdr[q] <= '0;
            end
        end else begin
            strm_start_pulse <= wr & ~is_hdr & (field == 2'd1) & pwdata[0];
            if (wr && !is_hdr && field == 2'd0) begin
                load_mode <= dma_mode_e'(pwdata[1:0]);
            end
            if (wr && !is_hdr && field == 2'd2) begin
                store_start_addr <= pwdata[GLB_ADDR_WIDTH-1:0];
            end
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                if (wr && is_hdr && hdr_sel == q) begin
                    case (field)
                        2'd0: hdr[q].start_addr <= pwdata[GLB_ADDR_WIDTH-1:0];
                        2'd1: begin
                            hdr[q].iteration.range[0] <= pwdata[0 +: MAX_RANGE_WIDTH];
                            hdr[q].iteration.range[1] <= pwdata[16 +: MAX_RANGE_WIDTH];
                        end
                        2'd2: begin
                            hdr[q].iteration.stride[0] <= pwdata[15:0];
                            hdr[q].iteration.stride[1] <= pwdata[31:16];
                        end
                        default: ;
                    endcase
                end
                // invalidation from the load DMA wins over a set
                if (load_invalidate_pulse[q]) begin
                    hdr[q].valid <= 1'b0;
                end else if (wr && is_hdr && hdr_sel == q && field == 2'd3 && pwdata[0]) begin
                    hdr[q].valid <= 1'b1;
                end
            end
        end
    end

    a_penable_with_psel: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> psel);

endmodule

/* design/glb_load_dma.sv */
// bank answers one cycle after a granted read; NORMAL mode runs whatever the header holds
`timescale 1ns/1ns

module glb_load_dma import glb_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  dma_mode_e              load_mode,
    input  dma_ld_header_t         load_header [QUEUE_DEPTH],
    output logic [QUEUE_DEPTH-1:0] load_invalidate_pulse,
    input  logic                   strm_start_pulse,
    output bank_req_t              bank_req,
    input  logic                   gnt,
    input  bank_rsp_t              bank_rsp,
    output cgra_data_t             stream_out_data,
    output logic                   stream_out_valid,
    output logic                   load_done_pulse
);

    localparam int QW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int SEL_W = BANK_BYTE_OFFSET - CGRA_BYTE_OFFSET;

    logic [QW-1:0] q_sel;
    logic dma_active;
    logic start_next;
    logic start_pulse_internal;
    logic strm_run;
    logic issue;
    logic rd_grant;
    logic last_elem;
    logic carry;
    glb_addr_t start_addr_r;
    loop_ctrl_t iter_r;
    glb_addr_t strm_addr;
    range_t itr [LOOP_LEVEL];
    range_t itr_next [LOOP_LEVEL];
    logic tag_valid;
    logic tag_last;
    logic [SEL_W-1:0] tag_sel;

    // auto restart needs a start first
    always_comb begin
        case (load_mode)
            NORMAL: start_next = strm_start_pulse & ~strm_run;
            REPEAT, AUTO_INCR: begin
                start_next = ~strm_run &
                    (strm_start_pulse | (dma_active & load_header[q_sel].valid));
            end
            default: start_next = 1'b0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            load_invalidate_pulse[i] = start_pulse_internal & (q_sel == i);
        end
    end

    assign rd_grant = issue & gnt;

    // start address plus each iterator times its stride
    always_comb begin
        strm_addr = start_addr_r;
        last_elem = 1'b1;
        for (int i = 0; i < LOOP_LEVEL; i++) begin
            strm_addr = strm_addr + glb_addr_t'(itr[i]) * iter_r.stride[i];
            last_elem = last_elem &
                ((iter_r.range[i] == '0) | (itr[i] == iter_r.range[i] - 1'b1));
        end
    end

    // inner level first, carry into the outer one on wrap
    always_comb begin
        itr_next = itr;
        carry = rd_grant;
        for (int i = 0; i < LOOP_LEVEL; i++) begin
            if (carry) begin
                if (iter_r.range[i] == '0 || itr[i] == iter_r.range[i] - 1'b1) begin
                    itr_next[i] = '0;
                end else begin
                    itr_next[i] = itr[i] + 1'b1;
                    carry = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sel <= '0;
            dma_active <= 1'b0;
            start_pulse_internal <= 1'b0;
            strm_run <= 1'b0;
            issue <= 1'b0;
            tag_valid <= 1'b0;
            tag_last <= 1'b0;
            for (int i = 0; i < LOOP_LEVEL; i++) begin
                itr[i] <= '0;
            end
        end else begin
            if (load_mode == REPEAT || load_mode == AUTO_INCR) begin
                dma_active <= dma_active | strm_start_pulse;
            end else begin
                dma_active <= 1'b0;
            end
            start_pulse_internal <= start_pulse_internal ? 1'b0 : start_next;
            if (start_pulse_internal) begin
                strm_run <= 1'b1;
            end else if (load_done_pulse) begin
                strm_run <= 1'b0;
            end
            if (start_pulse_internal) begin
                issue <= 1'b1;
            end else if (rd_grant && last_elem) begin
                issue <= 1'b0;
            end
            for (int i = 0; i < LOOP_LEVEL; i++) begin
                itr[i] <= start_pulse_internal ? '0 : itr_next[i];
            end
            tag_valid <= rd_grant;
            tag_last <= rd_grant & last_elem;
            if (load_mode != AUTO_INCR) begin
                q_sel <= '0;
            end else if (load_done_pulse) begin
                q_sel <= (q_sel == QW'(QUEUE_DEPTH - 1)) ? '0 : q_sel + 1'b1;
            end
        end
    end

    // header copy and word select of the read in flight
    always_ff @(posedge clk) begin
        if (start_pulse_internal) begin
            start_addr_r <= load_header[q_sel].start_addr;
            iter_r <= load_header[q_sel].iteration;
        end
        if (rd_grant) begin
            tag_sel <= strm_addr[BANK_BYTE_OFFSET-1:CGRA_BYTE_OFFSET];
        end
    end

    assign bank_req.rd_en = issue;
    assign bank_req.wr_en = 1'b0;
    assign bank_req.addr = strm_addr;
    assign bank_req.wr_data = '0;

    assign stream_out_valid = bank_rsp.rd_data_valid;
    assign stream_out_data = bank_rsp.rd_data[tag_sel*CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH];
    assign load_done_pulse = tag_valid & tag_last;

    a_rsp_has_tag: assert property (@(posedge clk) disable iff (reset)
        bank_rsp.rd_data_valid |-> tag_valid);

    a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
        start_pulse_internal |-> !strm_run && !tag_valid);

endmodule

/* design/glb_pkg.sv */
// shared types for one tile; fabric word 16 bits, bank word 64 bits, two loop levels only
package glb_pkg;

    localparam int GLB_ADDR_WIDTH = 16;
    localparam int CGRA_DATA_WIDTH = 16;
    localparam int BANK_DATA_WIDTH = 64;
    localparam int MAX_RANGE_WIDTH = 10;
    localparam int MAX_STRIDE_WIDTH = 16;
    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;
    localparam int LOOP_LEVEL = 2;
    localparam int BANK_BYTE_OFFSET = 3;
    localparam int CGRA_BYTE_OFFSET = 1;

    typedef logic [GLB_ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [CGRA_DATA_WIDTH-1:0] cgra_data_t;
    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [MAX_RANGE_WIDTH-1:0] range_t;
    typedef logic [MAX_STRIDE_WIDTH-1:0] stride_t;
    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

    typedef enum logic [1:0] {
        OFF       = 2'd0,
        NORMAL    = 2'd1,
        REPEAT    = 2'd2,
        AUTO_INCR = 2'd3
    } dma_mode_e;

    // level 0 is the inner loop
    typedef struct packed {
        range_t  [LOOP_LEVEL-1:0] range;
        stride_t [LOOP_LEVEL-1:0] stride;
    } loop_ctrl_t;

    typedef struct packed {
        logic       valid;
        glb_addr_t  start_addr;
        loop_ctrl_t iteration;
    } dma_ld_header_t;

    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        glb_addr_t  addr;
        bank_data_t wr_data;
    } bank_req_t;

    typedef struct packed {
        logic       rd_data_valid;
        bank_data_t rd_data;
    } bank_rsp_t;

endpackage

/* design/glb_store_dma.sv */
// fabric sends at most one word per cycle, so the single word buffer drains in time
`timescale 1ns/1ns

module glb_store_dma import glb_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  glb_addr_t  store_start_addr,
    input  logic       strm_start_pulse,
    input  cgra_data_t stream_in_data,
    input  logic       stream_in_valid,
    output bank_req_t  bank_req,
    input  logic       gnt
);

    localparam int SEL_W = BANK_BYTE_OFFSET - CGRA_BYTE_OFFSET;

    logic [SEL_W-1:0] cnt;
    logic full_word;
    bank_data_t pack;
    bank_data_t buf_data;
    logic buf_valid;
    glb_addr_t wr_addr;

    // fourth word completes a bank word
    assign full_word = stream_in_valid & (cnt == '1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
            buf_valid <= 1'b0;
            wr_addr <= '0;
        end else begin
            if (strm_start_pulse) begin
                cnt <= '0;
            end else if (stream_in_valid) begin
                cnt <= cnt + 1'b1;
            end
            if (full_word) begin
                buf_valid <= 1'b1;
            end else if (gnt) begin
                buf_valid <= 1'b0;
            end
            if (strm_start_pulse) begin
                wr_addr <= store_start_addr;
            end else if (gnt) begin
                wr_addr <= wr_addr + glb_addr_t'(1 << BANK_BYTE_OFFSET);
            end
        end
    end

    // first word ends up at byte offset 0
    always_ff @(posedge clk) begin
        if (stream_in_valid) begin
            pack <= {stream_in_data, pack[BANK_DATA_WIDTH-1:CGRA_DATA_WIDTH]};
        end
        if (full_word) begin
            buf_data <= {stream_in_data, pack[BANK_DATA_WIDTH-1:CGRA_DATA_WIDTH]};
        end
    end

    assign bank_req.rd_en = 1'b0;
    assign bank_req.wr_en = buf_valid;
    assign bank_req.addr = wr_addr;
    assign bank_req.wr_data = buf_data;

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        full_word |-> !buf_valid || gnt);

endmodule

/* design/glb_tile.sv */
// one bank tile; streams have no ready, the load stream stalls only on the bank grant
`timescale 1ns/1ns

module glb_tile import glb_pkg::*; #(
    parameter int QUEUE_DEPTH = 2,
    parameter int BANK_DEPTH = 256
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    input  cgra_data_t stream_in_data,
    input  logic       stream_in_valid,
    output cgra_data_t stream_out_data,
    output logic       stream_out_valid,
    output logic       load_done_pulse
);

    dma_mode_e load_mode;
    dma_ld_header_t load_header [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] load_invalidate_pulse;
    logic strm_start_pulse;
    glb_addr_t store_start_addr;
    bank_req_t store_req;
    bank_req_t load_req;
    bank_req_t bank_req;
    logic store_gnt;
    logic load_gnt;
    bank_rsp_t bank_rsp;
    bank_rsp_t load_rsp;

    glb_cfg_apb #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_cfg_apb (.*);

    glb_load_dma #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_load_dma (
        .clk, .reset, .load_mode, .load_header, .load_invalidate_pulse, .strm_start_pulse,
        .bank_req(load_req), .gnt(load_gnt), .bank_rsp(load_rsp),
        .stream_out_data, .stream_out_valid, .load_done_pulse
    );

    glb_store_dma u_store_dma (
        .clk, .reset, .store_start_addr, .strm_start_pulse, .stream_in_data,
        .stream_in_valid, .bank_req(store_req), .gnt(store_gnt)
    );

    glb_bank_arbiter u_arbiter (
        .clk, .reset, .store_req, .store_gnt, .load_req, .load_gnt,
        .bank_req, .bank_rsp_in(bank_rsp), .load_rsp
    );

    glb_bank #(.BANK_DEPTH(BANK_DEPTH)) u_bank (.clk, .bank_req, .bank_rsp);

endmodule

/* tb/tb_clk_gen.sv */
// free running clock from time zero; reset released on a rising edge after RESET_CYCLES
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* tb/tb_glb_tile.sv */
// model covers a 2048 byte bank; loads must only touch addresses the store stream wrote
`timescale 1ns/1ns

module tb_glb_tile import glb_pkg::*; ();

    // about ten times what the whole sequence needs
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        logic       last;
        cgra_data_t data;
    } exp_word_t;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic pready;
    logic pslverr;
    cgra_data_t stream_in_data;
    logic stream_in_valid;
    cgra_data_t stream_out_data;
    logic stream_out_valid;
    logic load_done_pulse;

    integer seed = 32'h5ce9;
    int mismatch_errors = 0;
    int other_errors = 0;
    int done_seen = 0;
    int exp_count = 0;
    cgra_data_t model_mem [1024];
    exp_word_t exp_q [$];
    exp_word_t exp_head;
    apb_data_t rd;
    logic err;

    tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clk_gen (.clk, .reset);

    glb_tile #(.QUEUE_DEPTH(2), .BANK_DEPTH(256)) u_glb_tile (.*);

    task automatic refresh_head();
        exp_count = exp_q.size();
        if (exp_q.size() > 0) begin
            exp_head = exp_q[0];
        end
    endtask

    // retire one expected word per output word
    always @(posedge clk) begin
        if (!reset && stream_out_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
        if (!reset && load_done_pulse) begin
            done_seen <= done_seen + 1;
        end
    end

    a_out_expected: assert property (@(posedge clk) disable iff (reset)
        stream_out_valid |-> exp_count > 0)
        else begin
            other_errors++;
            $display("unexpected output word at %0t, nothing was expected", $time);
        end

    a_out_data: assert property (@(posedge clk) disable iff (reset)
        stream_out_valid && exp_count > 0 |-> stream_out_data == exp_head.data)
        else begin
            mismatch_errors++;
            $display("mismatch at %0t: stream_out_data expected %h got %h", $time,
                $sampled(exp_head.data), $sampled(stream_out_data));
        end

    a_done_with_last: assert property (@(posedge clk) disable iff (reset)
        stream_out_valid && exp_count > 0 |-> load_done_pulse == exp_head.last)
        else begin
            mismatch_errors++;
            $display("mismatch at %0t: load_done_pulse expected %b got %b", $time,
                $sampled(exp_head.last), $sampled(load_done_pulse));
        end

    a_done_needs_word: assert property (@(posedge clk) disable iff (reset)
        load_done_pulse |-> stream_out_valid)
        else begin
            other_errors++;
            $display("load_done_pulse at %0t came without an output word", $time);
        end

    a_pready_high: assert property (@(posedge clk) disable iff (reset)
        pready)
        else begin
            mismatch_errors++;
            $display("mismatch at %0t: pready expected 1 got %b", $time, $sampled(pready));
        end

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic slverr);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // access cycle ends on this edge
        @(posedge clk);
        data = prdata;
        slverr = pslverr;
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input apb_addr_t addr, input apb_data_t expected);
        apb_data_t data;
        logic slverr;
        apb_read(addr, data, slverr);
        assert (data == expected)
            else begin
                mismatch_errors++;
                $display("mismatch at %0t: prdata at 0x%h expected %h got %h", $time, addr,
                    expected, data);
            end
        assert (!slverr)
            else begin
                other_errors++;
                $display("pslverr raised at %0t for mapped address 0x%h", $time, addr);
            end
    endtask

    task automatic write_header(input int q, input glb_addr_t start, input int r0, input int r1,
                                input int s0, input int s1);
        apb_addr_t base;
        base = apb_addr_t'(12'h010 + q * 12'h010);
        apb_write(base, apb_data_t'(start));
        apb_write(base + 12'h4, {6'b0, range_t'(r1), 6'b0, range_t'(r0)});
        apb_write(base + 12'h8, {stride_t'(s1), stride_t'(s0)});
    endtask

    // start plus each loop index times its stride with the inner loop first
    task automatic expect_run(input glb_addr_t start, input int r0, input int r1,
                              input int s0, input int s1);
        glb_addr_t a;
        exp_word_t e;
        for (int i1 = 0; i1 < r1; i1++) begin
            for (int i0 = 0; i0 < r0; i0++) begin
                a = glb_addr_t'(start + i0 * s0 + i1 * s1);
                e.data = model_mem[a[10:1]];
                e.last = (i0 == r0 - 1) && (i1 == r1 - 1);
                exp_q.push_back(e);
            end
        end
        refresh_head();
    endtask

    task automatic stream_words(input glb_addr_t base, input int n);
        cgra_data_t w;
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            w = cgra_data_t'($random(seed));
            stream_in_valid <= 1'b1;
            stream_in_data <= w;
            model_mem[base[10:1] + k] = w;
        end
        @(posedge clk);
        stream_in_valid <= 1'b0;
    endtask

    task automatic wait_dones(input int target);
        while (done_seen < target) begin
            @(posedge clk);
        end
    endtask

    task automatic check_drained();
        assert (exp_q.size() == 0)
            else begin
                other_errors++;
                $display("%0d expected output words never arrived by %0t", exp_q.size(), $time);
            end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        other_errors++;
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run();
    end

    initial begin
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        stream_in_valid = 1'b0;
        stream_in_data = '0;
        @(negedge reset);

        // register readback and an unmapped offset
        apb_write(12'h000, 32'd2);
        check_reg(12'h000, 32'd2);
        apb_write(12'h008, 32'h0000_0123);
        check_reg(12'h008, 32'h0000_0123);
        write_header(1, 16'h00a6, 3, 5, 16'h0010, 16'h0002);
        check_reg(12'h020, 32'h0000_00a6);
        check_reg(12'h024, 32'h0005_0003);
        check_reg(12'h028, 32'h0002_0010);
        check_reg(12'h02c, 32'h0);
        apb_write(12'h000, 32'd0);
        apb_read(12'h00c, rd, err);
        assert (err)
            else begin
                other_errors++;
                $display("pslverr stayed low at %0t for unmapped address 0x00c", $time);
            end

        // fill 64 words from address 0 with the load off
        apb_write(12'h008, 32'h0);
        apb_write(12'h004, 32'h1);
        stream_words(16'h0000, 64);

        // NORMAL load of 4 by 3 elements
        write_header(0, 16'h0006, 4, 3, 2, 16);
        apb_write(12'h01c, 32'h1);
        apb_write(12'h000, 32'd1);
        expect_run(16'h0006, 4, 3, 2, 16);
        apb_write(12'h004, 32'h1);
        wait_dones(1);
        check_drained();
        check_reg(12'h01c, 32'h0);

        // rerun on the stale header leaves valid clear
        expect_run(16'h0006, 4, 3, 2, 16);
        apb_write(12'h004, 32'h1);
        wait_dones(2);
        check_drained();
        check_reg(12'h01c, 32'h0);

        // AUTO_INCR walks header 0 then header 1
        write_header(1, 16'h0040, 3, 2, 8, 4);
        apb_write(12'h01c, 32'h1);
        apb_write(12'h02c, 32'h1);
        apb_write(12'h000, 32'd3);
        expect_run(16'h0006, 4, 3, 2, 16);
        expect_run(16'h0040, 3, 2, 8, 4);
        apb_write(12'h004, 32'h1);
        wait_dones(4);
        check_drained();

        // load from the low region while the store stream fills 0x200
        apb_write(12'h000, 32'd1);
        write_header(0, 16'h0000, 8, 4, 2, 16);
        apb_write(12'h008, 32'h0000_0200);
        expect_run(16'h0000, 8, 4, 2, 16);
        apb_write(12'h004, 32'h1);
        stream_words(16'h0200, 32);
        wait_dones(5);
        check_drained();

        // read back what was stored under contention
        write_header(0, 16'h0200, 8, 4, 2, 16);
        expect_run(16'h0200, 8, 4, 2, 16);
        apb_write(12'h004, 32'h1);
        wait_dones(6);
        check_drained();

        // OFF mode ignores the start even with a valid header
        apb_write(12'h000, 32'd0);
        apb_write(12'h01c, 32'h1);
        apb_write(12'h004, 32'h1);
        repeat (40) @(posedge clk);
        assert (done_seen == 6)
            else begin
                other_errors++;
                $display("load_done_pulse fired in OFF mode before %0t", $time);
            end

        finish_run();
    end

endmodule
